// File: sources.f
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/dcache_ctrl.sv
verilog/tag_cmp.sv
verilog/way_arrays.sv
verilog/miss_handler.sv
verilog/nb_dcache.sv
test/tb_mem_model.sv
test/nb_dcache_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"

test:
	verilator --binary --timing --assert -f sources.f --top-module nb_dcache_tb -Mdir build
	./build/Vnb_dcache_tb | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf build sim.log

// File: test/nb_dcache_tb.sv
module nb_dcache_tb;
  import dcache_pkg::*;

  // Fill pattern of the memory model
  localparam logic [31:0] INIT_XOR = 32'h5a5a_c3c3;
  // Requests issued over all tests
  localparam int NUM_REQ      = 324;
  localparam int FLUSH_CYCLES = 4 * NUM_SETS;
  localparam int MAX_CYCLES   = 16 + 200 * NUM_REQ + FLUSH_CYCLES;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        enable_i;
  logic        flush_i;
  logic        flush_ack_o;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic        ack_o;
  logic [31:0] rdata_o;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic        mem_ack_i;
  logic [31:0] mem_rdata_i;
  int unsigned rd_cnt;
  int unsigned wr_cnt;

  // Current request for the comparing process
  logic        cur_we;
  logic [31:0] cur_addr;
  logic [31:0] cur_wdata;
  int          exp_rd;
  int          exp_wr;
  int unsigned rd_base;
  int unsigned wr_base;
  logic        ack_d = 1'b0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'ha17e;
  // Last stored value per word address
  logic [31:0] shadow [logic [29:0]];

  always #5 clk_i = ~clk_i;

  nb_dcache #(
    .NUM_WAYS (2)
  ) UUT (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .flush_i     (flush_i),
    .flush_ack_o (flush_ack_o),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  tb_mem_model #(
    .INIT_XOR (INIT_XOR)
  ) u_mem (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .mem_req_i   (mem_req_o),
    .mem_we_i    (mem_we_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .mem_ack_o   (mem_ack_i),
    .mem_rdata_o (mem_rdata_i),
    .rd_cnt_o    (rd_cnt),
    .wr_cnt_o    (wr_cnt)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // 64 words with tag bits 9:8, index bits 5:4 and word bits 3:2
  function automatic logic [31:0] word_addr(input logic [5:0] n);
    return {22'b0, n[5:4], 2'b00, n[3:2], n[1:0], 2'b00};
  endfunction

  // Expected load is the last store or the memory fill pattern
  function automatic logic [31:0] expected_load(input logic [31:0] addr);
    if (shadow.exists(addr[31:2])) begin
      return shadow[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ INIT_XOR;
  endfunction

  // Full four-phase core access
  // Negative counts skip the count check
  task automatic run_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                            input int erd, input int ewr);
    @(posedge clk_i);
    #1;
    cur_we    = we;
    cur_addr  = addr;
    cur_wdata = data;
    exp_rd    = erd;
    exp_wr    = ewr;
    rd_base   = rd_cnt;
    wr_base   = wr_cnt;
    we_i      = we;
    addr_i    = addr;
    wdata_i   = data;
    req_i     = 1'b1;
    do @(posedge clk_i); while (!ack_o);
    #1 req_i = 1'b0;
    do @(posedge clk_i); while (ack_o);
  endtask

  task automatic run_flush();
    @(posedge clk_i);
    #1 flush_i = 1'b1;
    do @(posedge clk_i); while (!flush_ack_o);
    #1 flush_i = 1'b0;
    do @(posedge clk_i); while (flush_ack_o);
  endtask

  // --------------------
  // Comparing process
  // --------------------
  always @(posedge clk_i) begin
    ack_d <= ack_o;
    if (ack_o && !ack_d) begin
      if (!cur_we) begin
        assert (rdata_o == expected_load(cur_addr))
          else fail_value("rdata_o", rdata_o, expected_load(cur_addr));
      end else begin
        shadow[cur_addr[31:2]] = cur_wdata;
      end
      if (exp_rd >= 0) begin
        assert (int'(rd_cnt - rd_base) == exp_rd)
          else fail_value("mem reads", rd_cnt - rd_base, exp_rd);
      end
      if (exp_wr >= 0) begin
        assert (int'(wr_cnt - wr_base) == exp_wr)
          else fail_value("mem writes", wr_cnt - wr_base, exp_wr);
      end
    end
  end

  // Cycle limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < MAX_CYCLES)
      else stop_run("Simulation ran past its cycle limit without finishing");
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] a2;
    logic [31:0] d;
    arst_n_i = 1'b0;
    enable_i = 1'b1;
    flush_i  = 1'b0;
    req_i    = 1'b0;
    we_i     = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    repeat (16) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    // Cold miss refills a whole line
    a = word_addr(6'b01_10_11);
    run_access(1'b0, a, '0, LINE_WORDS, 0);
    // Other word of the same line hits
    run_access(1'b0, a ^ 32'h4, '0, 0, 0);

    // Store hit then load back
    take_bits(32, d);
    run_access(1'b1, a, d, 0, 1);
    run_access(1'b0, a, '0, 0, 0);
    // Store miss does not allocate
    a2 = word_addr(6'b11_00_01);
    take_bits(32, d);
    run_access(1'b1, a2, d, 0, 1);
    run_access(1'b0, a2, '0, LINE_WORDS, 0);

    // Random mix over colliding sets
    for (int i = 0; i < 300; i++) begin
      take_bits(1, bits);
      take_bits(6, a2);
      take_bits(32, d);
      run_access(bits[0], word_addr(a2[5:0]), d, bits[0] ? 0 : -1, bits[0] ? 1 : 0);
    end
    // Bring the first line back into the cache
    run_access(1'b0, a, '0, -1, 0);

    // One memory word per access with the cache off
    @(posedge clk_i);
    #1 enable_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      take_bits(1, bits);
      take_bits(6, a2);
      take_bits(32, d);
      run_access(bits[0], word_addr(a2[5:0]), d, bits[0] ? 0 : 1, bits[0] ? 1 : 0);
    end
    @(posedge clk_i);
    #1 enable_i = 1'b1;

    // Flushed line refills again
    run_flush();
    run_access(1'b0, a, '0, LINE_WORDS, 0);

    repeat (2) @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: test/tb_mem_model.sv
module tb_mem_model #(
  parameter logic [31:0] INIT_XOR = 32'h0
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Four-phase memory port
  input  logic        mem_req_i,
  input  logic        mem_we_i,
  input  logic [31:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  output logic        mem_ack_o,
  output logic [31:0] mem_rdata_o,
  // Transaction counters
  output int unsigned rd_cnt_o,
  output int unsigned wr_cnt_o
);

  // Sparse word storage keyed by word address
  logic [31:0] mem [logic [29:0]];

  // Unwritten words read back the fill pattern
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ INIT_XOR;
  endfunction

  // --------------------
  // Handshake responder
  // --------------------
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_ack_o   <= 1'b0;
      mem_rdata_o <= '0;
      rd_cnt_o    <= 0;
      wr_cnt_o    <= 0;
    end else if (mem_req_i && !mem_ack_o) begin
      // One word per transaction, counted at ack rise
      mem_ack_o <= 1'b1;
      if (mem_we_i) begin
        mem[mem_addr_i[31:2]] = mem_wdata_i;
        wr_cnt_o <= wr_cnt_o + 1;
      end else begin
        mem_rdata_o <= read_word(mem_addr_i);
        rd_cnt_o    <= rd_cnt_o + 1;
      end
    end else if (!mem_req_i && mem_ack_o) begin
      mem_ack_o <= 1'b0;
    end
  end

endmodule

// File: verilog/nb_dcache.sv
module nb_dcache #(
  parameter int NUM_WAYS = 2
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  // Flush handshake
  input  logic                          flush_i,
  output logic                          flush_ack_o,
  // Core port
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic [dcache_pkg::WORD_W-1:0] wdata_i,
  output logic                          ack_o,
  output logic [dcache_pkg::WORD_W-1:0] rdata_o,
  // Memory port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [dcache_pkg::WORD_W-1:0] mem_wdata_o,
  input  logic                          mem_ack_i,
  input  logic [dcache_pkg::WORD_W-1:0] mem_rdata_i
);

  // --------------------
  // Stage links
  // --------------------
  lookup_if                       lk_bus ();
  miss_if                         miss_bus ();
  fill_if                         fill_bus ();
  array_if #(.NUM_WAYS(NUM_WAYS)) arr_bus ();

  // Holds off new requests during flush
  logic flush_busy;

  // Request stage
  dcache_ctrl i_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .enable_i     (enable_i),
    .flush_busy_i (flush_busy),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .lk           (lk_bus),
    .miss         (miss_bus)
  );

  // Arbitration and tag compare
  tag_cmp #(
    .NUM_WAYS (NUM_WAYS)
  ) i_tag_cmp (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .lk       (lk_bus),
    .fill     (fill_bus),
    .arr      (arr_bus)
  );

  // Tag, valid and data storage
  way_arrays #(
    .NUM_WAYS (NUM_WAYS)
  ) i_arrays (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .arr      (arr_bus)
  );

  // Refill, write-through, bypass and flush
  miss_handler #(
    .NUM_WAYS (NUM_WAYS)
  ) i_miss_handler (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .flush_ack_o  (flush_ack_o),
    .flush_busy_o (flush_busy),
    .miss         (miss_bus),
    .fill         (fill_bus),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ack_i    (mem_ack_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

// File: verilog/miss_handler.sv
module miss_handler #(
  parameter int NUM_WAYS = 2
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Flush four-phase
  input  logic                          flush_i,
  output logic                          flush_ack_o,
  output logic                          flush_busy_o,
  // Controller and array paths
  miss_if.mh                            miss,
  fill_if.mh                            fill,
  // Memory four-phase port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [dcache_pkg::WORD_W-1:0] mem_wdata_o,
  input  logic                          mem_ack_i,
  input  logic [dcache_pkg::WORD_W-1:0] mem_rdata_i
);
  import dcache_pkg::*;

  localparam int       WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam way_sel_t ALL_WAYS = way_sel_t'((1 << NUM_WAYS) - 1);

  // FSM encoding
  localparam logic [2:0] M_IDLE  = 3'd0;
  localparam logic [2:0] M_MREQ  = 3'd1;
  localparam logic [2:0] M_MDROP = 3'd2;
  localparam logic [2:0] M_FILL  = 3'd3;
  localparam logic [2:0] M_ACK   = 3'd4;
  localparam logic [2:0] M_FLUSH = 3'd5;
  localparam logic [2:0] M_FACK  = 3'd6;

  logic [2:0]                     state_q;
  logic [OFF_W-1:0]               cnt_q;
  logic [IDX_W-1:0]               fidx_q;
  // Round-robin victim pointer per set
  logic [NUM_SETS-1:0][WAY_W-1:0] rr_q;
  cache_line_t                    buf_q;
  logic [WORD_W-1:0]              rdata_q;
  logic                           refill;
  logic [IDX_W-1:0]               idx;
  way_sel_t                       victim;

  assign refill = (miss.kind == KIND_REFILL);
  assign idx    = miss.addr.f.index;
  assign victim = way_sel_t'(1) << rr_q[idx];

  // --------------------
  // Sequencer
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
      fidx_q  <= '0;
      rr_q    <= '0;
    end else begin
      case (state_q)
        M_IDLE: begin
          cnt_q  <= '0;
          fidx_q <= '0;
          // Pending miss goes before a flush
          if (miss.req) begin
            state_q <= M_MREQ;
          end else if (flush_i) begin
            state_q <= M_FLUSH;
          end
        end
        M_MREQ: begin
          if (mem_ack_i) begin
            state_q <= M_MDROP;
          end
        end
        M_MDROP: begin
          if (!mem_ack_i) begin
            if (!refill) begin
              state_q <= M_ACK;
            end else if (cnt_q == OFF_W'(LINE_WORDS - 1)) begin
              state_q <= M_FILL;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= M_MREQ;
            end
          end
        end
        M_FILL: begin
          if (fill.gnt) begin
            if (rr_q[idx] == WAY_W'(NUM_WAYS - 1)) begin
              rr_q[idx] <= '0;
            end else begin
              rr_q[idx] <= rr_q[idx] + 1'b1;
            end
            state_q <= M_ACK;
          end
        end
        M_ACK: begin
          if (!miss.req) begin
            state_q <= M_IDLE;
          end
        end
        M_FLUSH: begin
          // One invalidate per set across all ways
          if (fill.gnt) begin
            fidx_q <= fidx_q + 1'b1;
            if (fidx_q == IDX_W'(NUM_SETS - 1)) begin
              state_q <= M_FACK;
            end
          end
        end
        M_FACK: begin
          if (!flush_i) begin
            state_q <= M_IDLE;
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // Line buffer and requested word
  always_ff @(posedge clk_i) begin
    if (state_q == M_MREQ && mem_ack_i) begin
      buf_q[cnt_q] <= mem_rdata_i;
      if (!refill || cnt_q == miss.addr.f.word) begin
        rdata_q <= mem_rdata_i;
      end
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign mem_req_o   = (state_q == M_MREQ);
  assign mem_we_o    = miss.kind[0];
  assign mem_addr_o  = refill ? {miss.addr.f.tag, idx, cnt_q, 2'b00} : miss.addr.flat;
  assign mem_wdata_o = miss.wdata;

  assign fill.req    = (state_q == M_FILL) || (state_q == M_FLUSH);
  assign fill.index  = (state_q == M_FLUSH) ? fidx_q : idx;
  assign fill.way    = (state_q == M_FLUSH) ? ALL_WAYS : victim;
  assign fill.tag    = miss.addr.f.tag;
  assign fill.valid  = (state_q != M_FLUSH);
  assign fill.line   = buf_q;

  assign miss.ack    = (state_q == M_ACK);
  assign miss.rdata  = rdata_q;

  assign flush_ack_o  = (state_q == M_FACK);
  assign flush_busy_o = flush_i || (state_q == M_FLUSH) || flush_ack_o;

  // Memory request and its fields held until acked
  a_mem_req_held : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)
                                     && $stable(mem_we_o) && $stable(mem_wdata_o))
  );

endmodule

// File: verilog/way_arrays.sv
module way_arrays #(
  parameter int NUM_WAYS = 2
) (
  input logic    clk_i,
  input logic    arst_n_i,
  array_if.slave arr
);
  import dcache_pkg::*;

  // Storage per way and set
  logic [TAG_W-1:0]                   tag_mem  [NUM_WAYS][NUM_SETS];
  cache_line_t                        line_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0]  valid_q;

  // Whole-line write carries tag and valid
  logic line_wr;

  assign line_wr = arr.en && arr.we && (arr.wword == '0);

  // --------------------
  // Valid bits
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q    <= '0;
      arr.rvalid <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (line_wr && arr.way_sel[w]) begin
          valid_q[w][arr.index] <= arr.wvalid;
        end
        if (arr.en && !arr.we) begin
          arr.rvalid[w] <= valid_q[w][arr.index];
        end
      end
    end
  end

  // --------------------
  // Tags and data
  // --------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (line_wr && arr.way_sel[w]) begin
        tag_mem[w][arr.index]  <= arr.wtag;
        line_mem[w][arr.index] <= arr.wline;
      end else if (arr.en && arr.we && arr.way_sel[w]) begin
        // Single word from a store hit
        for (int i = 0; i < LINE_WORDS; i++) begin
          if (arr.wword[i]) begin
            line_mem[w][arr.index][i] <= arr.wline[i];
          end
        end
      end
      // Registered read, one cycle latency
      if (arr.en && !arr.we) begin
        arr.rtag[w]  <= tag_mem[w][arr.index];
        arr.rline[w] <= line_mem[w][arr.index];
      end
    end
  end

endmodule

// File: verilog/tag_cmp.sv
module tag_cmp #(
  parameter int NUM_WAYS = 2
) (
  input logic     clk_i,
  input logic     arst_n_i,
  lookup_if.cmp   lk,
  fill_if.cmp     fill,
  array_if.master arr
);
  import dcache_pkg::*;

  // Read issued, compare done, store word pending
  logic              rd_q;
  logic              done_q;
  logic              st_q;
  logic              lk_go;
  logic              busy;
  // Compare path
  way_sel_t          hit_vec;
  logic [WORD_W-1:0] hit_word;
  logic              hit_q;
  way_sel_t          way_q;
  logic [WORD_W-1:0] rdata_q;

  assign busy  = rd_q || done_q;
  // Fill requests win over lookups
  assign lk_go = lk.valid && !fill.req && !busy;

  // --------------------
  // Array port mux
  // --------------------
  always_comb begin
    arr.en      = 1'b0;
    arr.we      = 1'b0;
    arr.index   = lk.addr.f.index;
    arr.way_sel = way_q;
    arr.wtag    = fill.tag;
    arr.wvalid  = fill.valid;
    arr.wline   = {LINE_WORDS{lk.wdata}};
    arr.wword   = '0;
    fill.gnt    = 1'b0;
    if (st_q) begin
      // Store hit updates one word of the hit way
      arr.en    = 1'b1;
      arr.we    = 1'b1;
      arr.wword = LINE_WORDS'(1) << lk.addr.f.word;
    end else if (fill.req && !busy) begin
      arr.en      = 1'b1;
      arr.we      = 1'b1;
      arr.index   = fill.index;
      arr.way_sel = fill.way;
      arr.wline   = fill.line;
      fill.gnt    = 1'b1;
    end else if (lk_go) begin
      arr.en = 1'b1;
    end
  end

  // Tag and valid compare per way
  always_comb begin
    hit_vec  = '0;
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.rvalid[w] && arr.rtag[w] == lk.addr.f.tag) begin
        hit_vec[w] = 1'b1;
        hit_word   = arr.rline[w][lk.addr.f.word];
      end
    end
  end

  // --------------------
  // Pipeline registers
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_q   <= 1'b0;
      done_q <= 1'b0;
      st_q   <= 1'b0;
    end else begin
      rd_q   <= lk_go;
      done_q <= rd_q;
      st_q   <= rd_q && lk.we && (|hit_vec);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_q) begin
      hit_q   <= |hit_vec;
      way_q   <= hit_vec;
      rdata_q <= hit_word;
    end
  end

  assign lk.done    = done_q;
  assign lk.hit     = hit_q;
  assign lk.hit_way = way_q;
  assign lk.rdata   = rdata_q;

  // A line lives in at most one way
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(lk.hit_way)
  );

endmodule

// File: verilog/dcache_ctrl.sv
module dcache_ctrl (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  input  logic                          flush_busy_i,
  // Core four-phase port
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic [dcache_pkg::WORD_W-1:0] wdata_i,
  output logic                          ack_o,
  output logic [dcache_pkg::WORD_W-1:0] rdata_o,
  // Downstream stages
  lookup_if.ctrl                        lk,
  miss_if.ctrl                          miss
);
  import dcache_pkg::*;

  // FSM encoding
  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_LOOKUP = 3'd1;
  localparam logic [2:0] S_MISS   = 3'd2;
  localparam logic [2:0] S_ACK    = 3'd3;
  localparam logic [2:0] S_DROP   = 3'd4;

  logic [2:0]        state_q;
  logic [1:0]        kind_q;
  // Request held for the whole transaction
  cache_addr_u       addr_q;
  logic              we_q;
  logic [WORD_W-1:0] wdata_q;
  logic [WORD_W-1:0] rdata_q;

  // --------------------
  // Request FSM
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      kind_q  <= KIND_REFILL;
    end else begin
      case (state_q)
        S_IDLE: begin
          // No new request while a flush runs
          if (req_i && !flush_busy_i) begin
            if (enable_i) begin
              state_q <= S_LOOKUP;
            end else begin
              state_q <= S_MISS;
              kind_q  <= we_i ? KIND_BYP_WR : KIND_BYP_RD;
            end
          end
        end
        S_LOOKUP: begin
          if (lk.done) begin
            // Only a load hit finishes here
            if (lk.hit && !we_q) begin
              state_q <= S_DROP;
            end else begin
              state_q <= S_MISS;
              kind_q  <= we_q ? KIND_WRITE : KIND_REFILL;
            end
          end
        end
        S_MISS: begin
          if (miss.ack) begin
            state_q <= S_ACK;
          end
        end
        S_ACK: begin
          // Miss handler closes its handshake
          if (!miss.ack) begin
            state_q <= S_DROP;
          end
        end
        S_DROP: begin
          if (!req_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Request capture and load data
  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && req_i) begin
      addr_q.flat <= addr_i;
      we_q        <= we_i;
      wdata_q     <= wdata_i;
    end
    if (state_q == S_LOOKUP && lk.done) begin
      rdata_q <= lk.rdata;
    end
    if (state_q == S_MISS && miss.ack) begin
      rdata_q <= miss.rdata;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign lk.valid   = (state_q == S_LOOKUP);
  assign lk.addr    = addr_q;
  assign lk.we      = we_q;
  assign lk.wdata   = wdata_q;

  assign miss.req   = (state_q == S_MISS);
  assign miss.kind  = kind_q;
  assign miss.addr  = addr_q;
  assign miss.wdata = wdata_q;

  // Ack held until the core drops req_i
  assign ack_o   = (state_q == S_DROP);
  assign rdata_o = rdata_q;

  // Core handshake order
  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $rose(ack_o) |-> req_i
  );

endmodule

// File: verilog/dcache_ifs.sv
// Controller to tag compare
interface lookup_if;
  import dcache_pkg::*;

  logic              valid;
  cache_addr_u       addr;
  logic              we;
  logic [WORD_W-1:0] wdata;
  // Compare result, done is a one-cycle pulse
  logic              done;
  logic              hit;
  way_sel_t          hit_way;
  logic [WORD_W-1:0] rdata;

  modport ctrl (output valid, addr, we, wdata, input done, hit, hit_way, rdata);
  modport cmp (input valid, addr, we, wdata, output done, hit, hit_way, rdata);
endinterface

// Controller to miss handler, four-phase
interface miss_if;
  import dcache_pkg::*;

  logic              req;
  logic [1:0]        kind;
  cache_addr_u       addr;
  logic [WORD_W-1:0] wdata;
  logic              ack;
  logic [WORD_W-1:0] rdata;

  modport ctrl (output req, kind, addr, wdata, input ack, rdata);
  modport mh (input req, kind, addr, wdata, output ack, rdata);
endinterface

// Miss handler write path into the arrays
interface fill_if;
  import dcache_pkg::*;

  logic             req;
  logic             gnt;
  logic [IDX_W-1:0] index;
  way_sel_t         way;
  logic [TAG_W-1:0] tag;
  logic             valid;
  cache_line_t      line;

  modport mh (output req, index, way, tag, valid, line, input gnt);
  modport cmp (input req, index, way, tag, valid, line, output gnt);
endinterface

// Single access port of the way arrays
interface array_if #(
  parameter int NUM_WAYS = 2
);
  import dcache_pkg::*;

  logic                             en;
  logic                             we;
  logic [IDX_W-1:0]                 index;
  way_sel_t                         way_sel;
  logic [TAG_W-1:0]                 wtag;
  logic                             wvalid;
  cache_line_t                      wline;
  // Word mask, zero writes the whole line
  logic [LINE_WORDS-1:0]            wword;
  logic [NUM_WAYS-1:0][TAG_W-1:0]   rtag;
  logic [NUM_WAYS-1:0]              rvalid;
  cache_line_t [NUM_WAYS-1:0]       rline;

  modport master (output en, we, index, way_sel, wtag, wvalid, wline, wword,
                  input rtag, rvalid, rline);
  modport slave (input en, we, index, way_sel, wtag, wvalid, wline, wword,
                 output rtag, rvalid, rline);
endinterface

// File: verilog/dcache_pkg.sv
package dcache_pkg;

  // --------------------
  // Cache geometry
  // --------------------
  localparam int WORD_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int NUM_SETS   = 16;
  localparam int LINE_WORDS = 4;
  localparam int TAG_W      = 24;

  // Index and word offset widths
  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);

  // Upper bound on associativity
  localparam int MAX_WAYS = 4;

  // --------------------
  // Miss request kinds
  // --------------------
  // Bit 0 set means a memory write
  // Bit 1 set means the cache is bypassed
  localparam logic [1:0] KIND_REFILL = 2'd0;
  localparam logic [1:0] KIND_WRITE  = 2'd1;
  localparam logic [1:0] KIND_BYP_RD = 2'd2;
  localparam logic [1:0] KIND_BYP_WR = 2'd3;

  // --------------------
  // Shared types
  // --------------------
  // Address as flat word or as cache fields
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] index;
      logic [OFF_W-1:0] word;
      logic [1:0]       byte_off;
    } f;
  } cache_addr_u;

  // One cache line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] cache_line_t;

  // One-hot way vector, low bits used when fewer ways
  typedef logic [MAX_WAYS-1:0] way_sel_t;

endpackage
